// ==== rtl/frame_fifo_params.svh ====
`ifndef FRAME_FIFO_PARAMS_SVH
`define FRAME_FIFO_PARAMS_SVH

// Buffer depth is 2**FIFO_ADDR_WIDTH entries
`define FIFO_ADDR_WIDTH 4

`define FIFO_DATA_WIDTH 8

// Width of each statistics counter
`define FIFO_STAT_WIDTH 16

`endif

// ==== rtl/frame_fifo_pkg.sv ====
`include "frame_fifo_params.svh"

package frame_fifo_pkg;

  // ----------------------------------------------------------
  // RAM word, one beat
  // ----------------------------------------------------------
  typedef struct packed {
    logic                        last;
    logic [`FIFO_DATA_WIDTH-1:0] data;
  } fifo_entry_t;

  // ----------------------------------------------------------
  // Frame outcome pulses, one cycle each
  // ----------------------------------------------------------
  typedef struct packed {
    // good frame committed
    logic commit;
    // frame ended while dropping for lack of room
    logic drop_full;
    // frame ended with tuser set
    logic drop_bad;
  } frame_event_t;

endpackage

// ==== rtl/frame_mem_if.sv ====
`timescale 1ns/1ps
`include "frame_fifo_params.svh"

interface frame_mem_if;
  import frame_fifo_pkg::*;

  // Write port
  logic                        wr_en;
  logic [`FIFO_ADDR_WIDTH-1:0] wr_addr;
  fifo_entry_t                 wr_entry;

  // Read port, combinational data
  logic [`FIFO_ADDR_WIDTH-1:0] rd_addr;
  fifo_entry_t                 rd_entry;

  modport ctrl (
    output wr_en,
    output wr_addr,
    output wr_entry,
    output rd_addr,
    input  rd_entry
  );

  modport ram (
    input  wr_en,
    input  wr_addr,
    input  wr_entry,
    input  rd_addr,
    output rd_entry
  );

endinterface

// ==== rtl/frame_fifo_ctrl.sv ====
`timescale 1ns/1ps
`include "frame_fifo_params.svh"

module frame_fifo_ctrl (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [`FIFO_DATA_WIDTH-1:0]   in_data,
  input  logic                          in_valid,
  input  logic                          in_last,
  input  logic                          in_user,
  input  logic                          accept,
  output logic                          load,
  output logic                          drop_frame,
  output frame_fifo_pkg::frame_event_t  events,
  frame_mem_if.ctrl                     mem
);
  import frame_fifo_pkg::*;

  localparam int AW = `FIFO_ADDR_WIDTH;
  localparam logic [AW:0] PTR_ONE = 1;

  // Pointers carry one wrap bit above the address
  logic [AW:0] wr_ptr_commit;
  logic [AW:0] wr_ptr_cur;
  logic [AW:0] rd_ptr;

  logic full;
  logic full_cur;
  logic empty;
  logic drop_beat;
  logic write;
  logic read;

  frame_event_t events_next;

  // ----------------------------------------------------------
  // Occupancy
  // ----------------------------------------------------------
  // Every written beat counts, committed or not
  assign full = (wr_ptr_cur[AW] != rd_ptr[AW]) &&
                (wr_ptr_cur[AW-1:0] == rd_ptr[AW-1:0]);

  // Current frame alone spans the whole depth
  assign full_cur = (wr_ptr_cur[AW] != wr_ptr_commit[AW]) &&
                    (wr_ptr_cur[AW-1:0] == wr_ptr_commit[AW-1:0]);

  // Reader only sees committed frames
  assign empty = (wr_ptr_commit == rd_ptr);

  assign drop_beat = in_valid && (full || full_cur || drop_frame);
  assign write     = in_valid && !drop_beat;

  assign read = accept && !empty;
  assign load = read;

  // ----------------------------------------------------------
  // RAM access
  // ----------------------------------------------------------
  assign mem.wr_en    = write;
  assign mem.wr_addr  = wr_ptr_cur[AW-1:0];
  assign mem.wr_entry = '{last: in_last, data: in_data};
  assign mem.rd_addr  = rd_ptr[AW-1:0];

  // ----------------------------------------------------------
  // Write side, commit and rollback
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_commit <= '0;
      wr_ptr_cur    <= '0;
      drop_frame    <= 1'b0;
    end else if (in_valid) begin
      if (drop_beat) begin
        // Stay in drop state until tlast, then discard
        drop_frame <= !in_last;
        if (in_last) begin
          wr_ptr_cur <= wr_ptr_commit;
        end
      end else if (in_last) begin
        if (in_user) begin
          wr_ptr_cur <= wr_ptr_commit;
        end else begin
          wr_ptr_cur    <= wr_ptr_cur + PTR_ONE;
          wr_ptr_commit <= wr_ptr_cur + PTR_ONE;
        end
      end else begin
        wr_ptr_cur <= wr_ptr_cur + PTR_ONE;
      end
    end
  end

  // ----------------------------------------------------------
  // Read side
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (read) begin
      rd_ptr <= rd_ptr + PTR_ONE;
    end
  end

  // ----------------------------------------------------------
  // Frame outcome events
  // ----------------------------------------------------------
  always_comb begin
    events_next = '0;
    if (in_valid && in_last) begin
      // Full drop takes priority over a bad flag
      if (drop_beat) begin
        events_next.drop_full = 1'b1;
      end else if (in_user) begin
        events_next.drop_bad = 1'b1;
      end else begin
        events_next.commit = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      events <= '0;
    end else begin
      events <= events_next;
    end
  end

endmodule

// ==== rtl/frame_ram.sv ====
`timescale 1ns/1ps
`include "frame_fifo_params.svh"

module frame_ram (
  input  logic     clk,
  frame_mem_if.ram mem
);
  import frame_fifo_pkg::*;

  localparam int DEPTH = 2 ** `FIFO_ADDR_WIDTH;

  fifo_entry_t store [DEPTH];

  // ----------------------------------------------------------
  // Synchronous write
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (mem.wr_en) begin
      store[mem.wr_addr] <= mem.wr_entry;
    end
  end

  // ----------------------------------------------------------
  // Asynchronous read
  // ----------------------------------------------------------
  // ctrl never writes a committed slot, so no bypass is needed
  assign mem.rd_entry = store[mem.rd_addr];

endmodule

// ==== rtl/axis_out_stage.sv ====
`timescale 1ns/1ps
`include "frame_fifo_params.svh"

module axis_out_stage (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         load,
  input  frame_fifo_pkg::fifo_entry_t  entry,
  input  logic                         out_ready,
  output logic                         accept,
  output logic [`FIFO_DATA_WIDTH-1:0]  out_data,
  output logic                         out_valid,
  output logic                         out_last
);
  import frame_fifo_pkg::*;

  fifo_entry_t entry_q;

  // Stage can take a new beat when empty or being drained
  assign accept = !out_valid || out_ready;

  // ----------------------------------------------------------
  // Valid bit
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= load;
    end
  end

  // ----------------------------------------------------------
  // Beat register
  // ----------------------------------------------------------
  // Holds under a stall since accept is low
  always_ff @(posedge clk) begin
    if (accept && load) begin
      entry_q <= entry;
    end
  end

  assign out_data = entry_q.data;
  assign out_last = entry_q.last;

endmodule

// ==== rtl/frame_stats.sv ====
`timescale 1ns/1ps
`include "frame_fifo_params.svh"

module frame_stats (
  input  logic                          clk,
  input  logic                          rst,
  input  frame_fifo_pkg::frame_event_t  events,
  output logic [`FIFO_STAT_WIDTH-1:0]   frames_committed,
  output logic [`FIFO_STAT_WIDTH-1:0]   frames_dropped_full,
  output logic [`FIFO_STAT_WIDTH-1:0]   frames_dropped_bad
);

  localparam int SW = `FIFO_STAT_WIDTH;
  localparam int NUM_CNT = 3;
  localparam logic [SW-1:0] CNT_MAX = '1;
  localparam logic [SW-1:0] CNT_ONE = 1;

  logic [NUM_CNT-1:0] pulse;
  logic [SW-1:0]      cnt [NUM_CNT];

  // Index 0 commit, 1 full drop, 2 bad drop
  assign pulse = {events.drop_bad, events.drop_full, events.commit};

  // ----------------------------------------------------------
  // Saturating counters
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_CNT; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_CNT; i++) begin
        if (pulse[i] && (cnt[i] != CNT_MAX)) begin
          cnt[i] <= cnt[i] + CNT_ONE;
        end
      end
    end
  end

  assign frames_committed    = cnt[0];
  assign frames_dropped_full = cnt[1];
  assign frames_dropped_bad  = cnt[2];

endmodule

// ==== rtl/frame_fifo_top.sv ====
`timescale 1ns/1ps
`include "frame_fifo_params.svh"

module frame_fifo_top (
  input  logic                         clk,
  input  logic                         rst,

  // Ingress, no ready
  input  logic [`FIFO_DATA_WIDTH-1:0]  in_data,
  input  logic                         in_valid,
  input  logic                         in_last,
  input  logic                         in_user,

  // Egress
  output logic [`FIFO_DATA_WIDTH-1:0]  out_data,
  output logic                         out_valid,
  input  logic                         out_ready,
  output logic                         out_last,

  // Status
  output logic                         drop_frame,
  output logic [`FIFO_STAT_WIDTH-1:0]  frames_committed,
  output logic [`FIFO_STAT_WIDTH-1:0]  frames_dropped_full,
  output logic [`FIFO_STAT_WIDTH-1:0]  frames_dropped_bad
);
  import frame_fifo_pkg::*;

  logic         load;
  logic         accept;
  frame_event_t events;

  frame_mem_if mem_if ();

  // ----------------------------------------------------------
  // Control core
  // ----------------------------------------------------------
  frame_fifo_ctrl i_ctrl (
    .clk        (clk),
    .rst        (rst),
    .in_data    (in_data),
    .in_valid   (in_valid),
    .in_last    (in_last),
    .in_user    (in_user),
    .accept     (accept),
    .load       (load),
    .drop_frame (drop_frame),
    .events     (events),
    .mem        (mem_if.ctrl)
  );

  frame_ram i_ram (
    .clk (clk),
    .mem (mem_if.ram)
  );

  // ----------------------------------------------------------
  // Egress register and counters
  // ----------------------------------------------------------
  // Out stage reads the RAM word addressed by ctrl
  axis_out_stage i_out_stage (
    .clk       (clk),
    .rst       (rst),
    .load      (load),
    .entry     (mem_if.rd_entry),
    .out_ready (out_ready),
    .accept    (accept),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_last  (out_last)
  );

  frame_stats i_stats (
    .clk                 (clk),
    .rst                 (rst),
    .events              (events),
    .frames_committed    (frames_committed),
    .frames_dropped_full (frames_dropped_full),
    .frames_dropped_bad  (frames_dropped_bad)
  );

endmodule

// ==== dv/frame_fifo_asserts.sv ====
`timescale 1ns/1ps
`include "frame_fifo_params.svh"

module frame_fifo_asserts (
  input logic                          clk,
  input logic                          rst,
  input logic [`FIFO_DATA_WIDTH-1:0]   out_data,
  input logic                          out_valid,
  input logic                          out_ready,
  input logic                          out_last,
  input logic                          drop_frame,
  input frame_fifo_pkg::frame_event_t  events
);

  // ------------------------------------------------------------
  // Egress stall
  // ------------------------------------------------------------
  a_valid_held: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid)
    else $error("out_valid fell while the beat was stalled");

  a_beat_held: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> $stable(out_data) && $stable(out_last))
    else $error("egress beat changed while stalled");

  // ------------------------------------------------------------
  // Reset and events
  // ------------------------------------------------------------
  a_reset_quiet: assert property (@(posedge clk)
    rst |=> !out_valid && !drop_frame)
    else $error("out_valid or drop_frame high after a reset cycle");

  // Committed frame reaches the egress register
  a_commit_to_egress: assert property (@(posedge clk) disable iff (rst)
    events.commit |=> out_valid)
    else $error("out_valid low the cycle after a frame commit");

endmodule

// ==== dv/frame_fifo_tb.sv ====
`timescale 1ns/1ps
`include "frame_fifo_params.svh"

module frame_fifo_tb;
  import frame_fifo_pkg::*;

  localparam int DW = `FIFO_DATA_WIDTH;
  localparam int SW = `FIFO_STAT_WIDTH;
  localparam int DEPTH = 2 ** `FIFO_ADDR_WIDTH;
  localparam int RESET_CYCLES = 5;
  localparam int RAND_FRAMES = 12;
  localparam int OVERSIZE_LEN = DEPTH + 4;
  // Rough cycles per test, random traffic at about half throughput
  localparam int TEST_CYCLES = 70 + 30 + 50 + 60 + RAND_FRAMES * 8 * 3;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 2 * TEST_CYCLES;
  localparam int COMMIT = 0;
  localparam int DROP_FULL = 1;
  localparam int DROP_BAD = 2;

  logic          clk = 1'b0;
  logic          rst;
  logic [DW-1:0] in_data;
  logic          in_valid;
  logic          in_last;
  logic          in_user;
  logic [DW-1:0] out_data;
  logic          out_valid;
  logic          out_ready;
  logic          out_last;
  logic          drop_frame;
  logic [SW-1:0] frames_committed;
  logic [SW-1:0] frames_dropped_full;
  logic [SW-1:0] frames_dropped_bad;

  integer        seed = 32'h8aa9;
  bit            rand_ready = 1'b0;
  logic [31:0]   ready_draw;
  fifo_entry_t   exp_q [$];
  fifo_entry_t   exp_beat;
  logic [SW-1:0] exp_commit = '0;
  logic [SW-1:0] exp_full = '0;
  logic [SW-1:0] exp_bad = '0;

  always #5 clk = ~clk;

  frame_fifo_top i_dut (
    .clk                 (clk),
    .rst                 (rst),
    .in_data             (in_data),
    .in_valid            (in_valid),
    .in_last             (in_last),
    .in_user             (in_user),
    .out_data            (out_data),
    .out_valid           (out_valid),
    .out_ready           (out_ready),
    .out_last            (out_last),
    .drop_frame          (drop_frame),
    .frames_committed    (frames_committed),
    .frames_dropped_full (frames_dropped_full),
    .frames_dropped_bad  (frames_dropped_bad)
  );

  bind frame_fifo_top frame_fifo_asserts i_asserts (
    .clk        (clk),
    .rst        (rst),
    .out_data   (out_data),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_last   (out_last),
    .drop_frame (drop_frame),
    .events     (events)
  );

  task automatic report_error(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  // ------------------------------------------------------------
  // Reference model and monitor
  // ------------------------------------------------------------
  // RAM plus the out register hold DEPTH + 1 beats under a stall
  function automatic int frame_outcome(input int len, input bit bad, input int held);
    if (len > DEPTH || held + len > DEPTH + 1) begin
      return DROP_FULL;
    end else if (bad) begin
      return DROP_BAD;
    end
    return COMMIT;
  endfunction

  always @(posedge clk) begin
    if (out_valid && out_ready) begin
      assert (exp_q.size() != 0) else report_error("egress beat with none expected");
      exp_beat = exp_q.pop_front();
      assert (out_data == exp_beat.data)
        else report_error($sformatf("out_data %0h, expected %0h", out_data, exp_beat.data));
      assert (out_last == exp_beat.last)
        else report_error($sformatf("out_last %0b, expected %0b", out_last, exp_beat.last));
    end
  end

  // Ready drawn at the falling edge, applied after the rising edge
  always begin
    @(negedge clk);
    ready_draw = $random(seed);
    @(posedge clk);
    #1;
    if (rand_ready) begin
      out_ready = ready_draw[0];
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles, the testbench is stuck waiting", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  end

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------
  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic drive_beat(input logic [DW-1:0] data, input bit last, input bit user);
    in_valid = 1'b1;
    in_data  = data;
    in_last  = last;
    in_user  = user;
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    in_last  = 1'b0;
    in_user  = 1'b0;
  endtask

  task automatic send_frame(input int len, input bit bad);
    int          outcome;
    logic [31:0] rnd;
    fifo_entry_t beat;
    fifo_entry_t beats [$];
    outcome = frame_outcome(len, bad, exp_q.size());
    for (int i = 0; i < len; i++) begin
      rnd = $random(seed);
      beat.data = rnd[DW-1:0];
      beat.last = (i == len - 1);
      beats.push_back(beat);
      drive_beat(beat.data, beat.last, bad && beat.last);
    end
    if (outcome == COMMIT) begin
      foreach (beats[k]) begin
        exp_q.push_back(beats[k]);
      end
      exp_commit++;
    end else if (outcome == DROP_BAD) begin
      exp_bad++;
    end else begin
      exp_full++;
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
    // Room for the counter update and any stray beat
    idle_cycles(4);
  endtask

  task automatic check_counters();
    assert (frames_committed == exp_commit)
      else report_error($sformatf("committed %0d, expected %0d", frames_committed, exp_commit));
    assert (frames_dropped_full == exp_full)
      else report_error($sformatf("full drops %0d, expected %0d", frames_dropped_full, exp_full));
    assert (frames_dropped_bad == exp_bad)
      else report_error($sformatf("bad drops %0d, expected %0d", frames_dropped_bad, exp_bad));
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic timed_good_frame(input int len);
    send_frame(len, 1'b0);
    assert (out_valid == 1'b0) else report_error("out_valid high on the tlast edge");
    idle_cycles(1);
    assert (out_valid == 1'b1) else report_error("out_valid low one cycle after tlast");
    wait_drain();
  endtask

  task automatic good_frames();
    timed_good_frame(1);
    timed_good_frame(5);
    timed_good_frame(DEPTH);
    check_counters();
  endtask

  task automatic bad_frame_between();
    send_frame(3, 1'b0);
    send_frame(4, 1'b1);
    send_frame(2, 1'b0);
    wait_drain();
    check_counters();
  endtask

  task automatic oversize_frame();
    logic [31:0] rnd;
    bit          exp_drop;
    for (int i = 0; i < OVERSIZE_LEN; i++) begin
      rnd = $random(seed);
      drive_beat(rnd[DW-1:0], i == OVERSIZE_LEN - 1, 1'b0);
      // First beat past the depth starts the drop
      exp_drop = (i >= DEPTH) && (i != OVERSIZE_LEN - 1);
      assert (drop_frame == exp_drop)
        else report_error($sformatf("drop_frame %0b after beat %0d", drop_frame, i));
    end
    exp_full++;
    send_frame(4, 1'b0);
    wait_drain();
    check_counters();
  endtask

  task automatic overflow_backpressure();
    out_ready = 1'b0;
    for (int f = 0; f < 4; f++) begin
      send_frame(6, 1'b0);
      idle_cycles(2);
    end
    out_ready = 1'b1;
    wait_drain();
    check_counters();
  endtask

  task automatic random_ready_traffic();
    logic [31:0] rnd;
    int          len;
    rand_ready = 1'b1;
    for (int f = 0; f < RAND_FRAMES; f++) begin
      rnd = $random(seed);
      len = int'(rnd[2:0]) + 1;
      // Keep the stored total within the depth
      while (exp_q.size() + len > DEPTH) begin
        idle_cycles(1);
      end
      send_frame(len, 1'b0);
    end
    rand_ready = 1'b0;
    idle_cycles(1);
    out_ready = 1'b1;
    wait_drain();
    check_counters();
  endtask

  initial begin
    rst       = 1'b1;
    in_data   = '0;
    in_valid  = 1'b0;
    in_last   = 1'b0;
    in_user   = 1'b0;
    out_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    idle_cycles(2);
    good_frames();
    bad_frame_between();
    oversize_frame();
    overflow_backpressure();
    random_ready_traffic();
    check_counters();
    if (exp_q.size() == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      report_error("expected beats left over at the end");
    end
  end

endmodule

// ==== flist.f ====
+incdir+rtl
rtl/frame_fifo_pkg.sv
rtl/frame_mem_if.sv
rtl/frame_fifo_ctrl.sv
rtl/frame_ram.sv
rtl/axis_out_stage.sv
rtl/frame_stats.sv
rtl/frame_fifo_top.sv
dv/frame_fifo_asserts.sv
dv/frame_fifo_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := frame_fifo_tb
RTL_TOP    := frame_fifo_top
FLIST      := flist.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
